/* wb_pkg.sv */
package wb_pkg;

    localparam int NUM_SLOTS        = 4;
    localparam int DATA_W           = 64;
    localparam int ADDR_W           = 32;
    localparam int REG_IDX_W        = 3;
    localparam int NUM_REGS         = 8;

    localparam int WBAQ_DEPTH       = 8;

    localparam int MEM_GAP          = 3;    // idle cycles after a memory write
    localparam int GAP_W            = 2;

    localparam int FETCH_LINE_BYTES = 16;

    typedef logic [DATA_W-1:0] gpr_t;
    typedef logic [15:0]       seg_t;

    // 0 byte, 1 word, 2 dword, 3 qword
    typedef logic [1:0] size_t;

    localparam size_t SZ_QWORD = 2'd3;

endpackage

/* wb_stage.sv */
module wb_stage
    import wb_pkg::*;
(
    input  logic                                 valid_in,
    input  logic [ADDR_W-1:0]                    eip_in,
    input  logic [ADDR_W-1:0]                    br_fip_in,
    input  logic                                 br_taken_in,
    input  logic                                 br_correct_in,
    input  logic                                 far_xfer,
    input  logic                                 ie_in,
    input  logic [3:0]                           ie_type_in,
    input  logic                                 interrupt_in,

    input  logic [DATA_W-1:0]                    inp1, inp2, inp3, inp4,
    input  logic [ADDR_W-1:0]                    inp1_dest, inp2_dest, inp3_dest, inp4_dest,
    input  logic                                 inp1_is_reg, inp2_is_reg, inp3_is_reg, inp4_is_reg,
    input  logic                                 inp1_is_seg, inp2_is_seg, inp3_is_seg, inp4_is_seg,
    input  logic                                 inp1_is_mem, inp2_is_mem, inp3_is_mem, inp4_is_mem,
    input  logic                                 inp1_wb, inp2_wb, inp3_wb, inp4_wb,
    input  size_t                                inpsize,

    input  logic                                 wbaq_full,

    output logic                                 valid_out,
    output logic                                 stall,
    output logic [NUM_SLOTS-1:0]                 reg_ld,
    output logic [NUM_SLOTS-1:0]                 seg_ld,
    output logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]  reg_idx,
    output logic                                 wbaq_push,
    output logic [ADDR_W-1:0]                    st_addr,
    output logic [DATA_W-1:0]                    st_data,
    output size_t                                st_size,
    output logic [ADDR_W-1:0]                    new_eip,
    output logic [ADDR_W-1:0]                    new_fip_e,
    output logic [ADDR_W-1:0]                    new_fip_o,
    output logic                                 is_resteer,
    output logic                                 final_ie_val,
    output logic [3:0]                           final_ie_type,
    output logic [DATA_W-1:0]                    slot1_res
);

    logic [NUM_SLOTS-1:0]              is_reg;
    logic [NUM_SLOTS-1:0]              is_seg;
    logic [NUM_SLOTS-1:0]              is_mem;
    logic [NUM_SLOTS-1:0]              wb;
    logic [NUM_SLOTS-1:0][DATA_W-1:0]  data;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0]  dest;
    logic                              any_mem;
    logic [ADDR_W-1:0]                 target;
    logic [ADDR_W-1:0]                 line_base;
    logic [ADDR_W-1:0]                 line_next;

    assign is_reg = {inp4_is_reg, inp3_is_reg, inp2_is_reg, inp1_is_reg};
    assign is_seg = {inp4_is_seg, inp3_is_seg, inp2_is_seg, inp1_is_seg};
    assign is_mem = {inp4_is_mem, inp3_is_mem, inp2_is_mem, inp1_is_mem};
    assign wb     = {inp4_wb, inp3_wb, inp2_wb, inp1_wb};
    assign data   = {inp4, inp3, inp2, inp1};
    assign dest   = {inp4_dest, inp3_dest, inp2_dest, inp1_dest};

    assign any_mem   = |is_mem;
    assign stall     = valid_in & any_mem & wbaq_full;  // hold until queue has room
    assign valid_out = valid_in & ~stall;

    assign reg_ld = is_reg & wb & {NUM_SLOTS{valid_out}};
    assign seg_ld = is_seg & wb & {NUM_SLOTS{valid_out}};

    always_comb begin
        for (int n = 0; n < NUM_SLOTS; n++) begin
            reg_idx[n] = dest[n][REG_IDX_W-1:0];
        end
    end

    // slot 1 carries CS in 47:32 on a far transfer
    assign slot1_res = far_xfer ? DATA_W'(inp1[47:32]) : inp1;

    assign wbaq_push = valid_out & any_mem;
    assign st_size   = far_xfer ? SZ_QWORD : inpsize;

    always_comb begin
        st_addr = dest[0];
        st_data = data[0];
        for (int n = NUM_SLOTS - 1; n >= 0; n--) begin  // lowest mem slot ends up last
            if (is_mem[n]) begin
                st_addr = dest[n];
                st_data = data[n];
            end
        end
    end

    assign target  = far_xfer ? inp1[ADDR_W-1:0] : br_fip_in;
    assign new_eip = br_taken_in ? target : eip_in;

    assign line_base = target & ~(ADDR_W'(FETCH_LINE_BYTES) - 1'b1);
    assign line_next = line_base + ADDR_W'(FETCH_LINE_BYTES);

    always_comb begin
        if ((target & ADDR_W'(FETCH_LINE_BYTES)) == '0) begin  // target on even line
            new_fip_e = line_base;
            new_fip_o = line_next;
        end else begin
            new_fip_e = line_next;
            new_fip_o = line_base;
        end
    end

    assign is_resteer    = ~br_correct_in;
    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]};

endmodule

/* wb_regfile.sv */
module wb_regfile
    import wb_pkg::*;
#(
    parameter type entry_t = gpr_t
)(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [NUM_SLOTS-1:0]                 wr_en,
    input  logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]  wr_idx,
    input  entry_t [NUM_SLOTS-1:0]               wr_data,
    input  logic [REG_IDX_W-1:0]                 rd_idx,
    output entry_t                               rd_data
);

    entry_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int n = 0; n < NUM_SLOTS; n++) begin  // higher slot overrides lower
                if (wr_en[n]) begin
                    regs[wr_idx[n]] <= wr_data[n];
                end
            end
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

/* wbaq_fifo.sv */
module wbaq_fifo
    import wb_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  logic [ADDR_W-1:0]  push_addr,
    input  logic [DATA_W-1:0]  push_data,
    input  size_t              push_size,
    input  logic               pop,
    output logic               full,
    output logic               empty,
    output logic [ADDR_W-1:0]  head_addr,
    output logic [DATA_W-1:0]  head_data,
    output size_t              head_size
);

    logic [ADDR_W-1:0]                 addr_mem [WBAQ_DEPTH];
    logic [DATA_W-1:0]                 data_mem [WBAQ_DEPTH];
    size_t                             size_mem [WBAQ_DEPTH];
    logic [$clog2(WBAQ_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(WBAQ_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(WBAQ_DEPTH+1)-1:0]   count;
    logic                              do_push;
    logic                              do_pop;

    assign full  = (count == WBAQ_DEPTH);
    assign empty = (count == '0);

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
            size_mem[wr_ptr] <= push_size;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_size = size_mem[rd_ptr];

endmodule

/* wbaq_drain_fsm.sv */
module wbaq_drain_fsm
    import wb_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               empty,
    input  logic [ADDR_W-1:0]  head_addr,
    input  logic [DATA_W-1:0]  head_data,
    input  size_t              head_size,
    input  logic               mem_ready,
    input  logic               gap_done,
    output logic               pop,
    output logic               gap_load,
    output logic               mem_we,
    output logic [ADDR_W-1:0]  mem_waddr,
    output logic [DATA_W-1:0]  mem_wdata,
    output size_t              mem_wsize
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        GAP
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   start;

    assign start    = (state == IDLE) & ~empty & mem_ready;
    assign pop      = start;
    assign gap_load = start;     // gap counted from the issue cycle
    assign mem_we   = (state == ISSUE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = ISSUE;
            ISSUE:   state_nxt = GAP;
            GAP:     if (gap_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin  // head held on the port through ISSUE
            mem_waddr <= head_addr;
            mem_wdata <= head_data;
            mem_wsize <= head_size;
        end
    end

endmodule

/* wb_gap_timer.sv */
module wb_gap_timer
    import wb_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  load,
    output logic  done
);

    logic [GAP_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= GAP_W'(MEM_GAP);
        end else if (count != '0) begin
            count <= count - 1'b1;  // stops at zero
        end
    end

    assign done = (count == '0);

endmodule

/* wb_top.sv */
module wb_top
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  valid_in,
    input  logic [ADDR_W-1:0]     eip_in,
    input  logic [ADDR_W-1:0]     br_fip_in,
    input  logic                  br_taken_in,
    input  logic                  br_correct_in,
    input  logic                  far_xfer,
    input  logic                  ie_in,
    input  logic [3:0]            ie_type_in,
    input  logic                  interrupt_in,

    input  logic [DATA_W-1:0]     inp1, inp2, inp3, inp4,
    input  logic [ADDR_W-1:0]     inp1_dest, inp2_dest, inp3_dest, inp4_dest,
    input  logic                  inp1_is_reg, inp2_is_reg, inp3_is_reg, inp4_is_reg,
    input  logic                  inp1_is_seg, inp2_is_seg, inp3_is_seg, inp4_is_seg,
    input  logic                  inp1_is_mem, inp2_is_mem, inp3_is_mem, inp4_is_mem,
    input  logic                  inp1_wb, inp2_wb, inp3_wb, inp4_wb,
    input  size_t                 inpsize,

    input  logic                  mem_ready,
    input  logic [REG_IDX_W-1:0]  gpr_rd_addr,
    input  logic [REG_IDX_W-1:0]  seg_rd_addr,

    output logic                  valid_out,
    output logic                  stall,
    output logic [ADDR_W-1:0]     new_eip,
    output logic [ADDR_W-1:0]     new_fip_e,
    output logic [ADDR_W-1:0]     new_fip_o,
    output logic                  is_resteer,
    output logic                  final_ie_val,
    output logic [3:0]            final_ie_type,
    output logic                  mem_we,
    output logic [ADDR_W-1:0]     mem_waddr,
    output logic [DATA_W-1:0]     mem_wdata,
    output size_t                 mem_wsize,
    output gpr_t                  gpr_rd_data,
    output seg_t                  seg_rd_data
);

    logic [NUM_SLOTS-1:0]                 reg_ld;
    logic [NUM_SLOTS-1:0]                 seg_ld;
    logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]  reg_idx;
    logic [DATA_W-1:0]                    slot1_res;
    logic                                 wbaq_push;
    logic                                 wbaq_full;
    logic                                 wbaq_empty;
    logic                                 wbaq_pop;
    logic [ADDR_W-1:0]                    st_addr;
    logic [DATA_W-1:0]                    st_data;
    size_t                                st_size;
    logic [ADDR_W-1:0]                    head_addr;
    logic [DATA_W-1:0]                    head_data;
    size_t                                head_size;
    logic                                 gap_load;
    logic                                 gap_done;
    gpr_t [NUM_SLOTS-1:0]                 gpr_wdata;
    seg_t [NUM_SLOTS-1:0]                 seg_wdata;

    assign gpr_wdata = {inp4, inp3, inp2, slot1_res};
    assign seg_wdata = {inp4[15:0], inp3[15:0], inp2[15:0], slot1_res[15:0]};  // selector bits

    wb_stage u_stage (
        .valid_in      (valid_in),
        .eip_in        (eip_in),
        .br_fip_in     (br_fip_in),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .far_xfer      (far_xfer),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .inp1          (inp1),
        .inp2          (inp2),
        .inp3          (inp3),
        .inp4          (inp4),
        .inp1_dest     (inp1_dest),
        .inp2_dest     (inp2_dest),
        .inp3_dest     (inp3_dest),
        .inp4_dest     (inp4_dest),
        .inp1_is_reg   (inp1_is_reg),
        .inp2_is_reg   (inp2_is_reg),
        .inp3_is_reg   (inp3_is_reg),
        .inp4_is_reg   (inp4_is_reg),
        .inp1_is_seg   (inp1_is_seg),
        .inp2_is_seg   (inp2_is_seg),
        .inp3_is_seg   (inp3_is_seg),
        .inp4_is_seg   (inp4_is_seg),
        .inp1_is_mem   (inp1_is_mem),
        .inp2_is_mem   (inp2_is_mem),
        .inp3_is_mem   (inp3_is_mem),
        .inp4_is_mem   (inp4_is_mem),
        .inp1_wb       (inp1_wb),
        .inp2_wb       (inp2_wb),
        .inp3_wb       (inp3_wb),
        .inp4_wb       (inp4_wb),
        .inpsize       (inpsize),
        .wbaq_full     (wbaq_full),
        .valid_out     (valid_out),
        .stall         (stall),
        .reg_ld        (reg_ld),
        .seg_ld        (seg_ld),
        .reg_idx       (reg_idx),
        .wbaq_push     (wbaq_push),
        .st_addr       (st_addr),
        .st_data       (st_data),
        .st_size       (st_size),
        .new_eip       (new_eip),
        .new_fip_e     (new_fip_e),
        .new_fip_o     (new_fip_o),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .slot1_res     (slot1_res)
    );

    wb_regfile #(.entry_t(gpr_t)) u_gpr (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (reg_ld),
        .wr_idx  (reg_idx),
        .wr_data (gpr_wdata),
        .rd_idx  (gpr_rd_addr),
        .rd_data (gpr_rd_data)
    );

    wb_regfile #(.entry_t(seg_t)) u_seg (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (seg_ld),
        .wr_idx  (reg_idx),
        .wr_data (seg_wdata),
        .rd_idx  (seg_rd_addr),
        .rd_data (seg_rd_data)
    );

    wbaq_fifo u_wbaq (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (wbaq_push),
        .push_addr (st_addr),
        .push_data (st_data),
        .push_size (st_size),
        .pop       (wbaq_pop),
        .full      (wbaq_full),
        .empty     (wbaq_empty),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_size (head_size)
    );

    wbaq_drain_fsm u_drain (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (wbaq_empty),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_size (head_size),
        .mem_ready (mem_ready),
        .gap_done  (gap_done),
        .pop       (wbaq_pop),
        .gap_load  (gap_load),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wsize (mem_wsize)
    );

    wb_gap_timer u_gap (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (gap_load),
        .done   (gap_done)
    );

endmodule

/* wb_clkgen.sv */
module wb_clkgen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;  // period 4
    end

endmodule

/* wb_properties.sv */
module wb_properties (
    input logic clk,
    input logic arst_n,
    input logic stall,
    input logic valid_out,
    input logic mem_we,
    input logic wbaq_empty
);

    int fail_cnt = 0;

    stall_blocks_valid: assert property (
        @(posedge clk) disable iff (!arst_n) stall |-> !valid_out
    ) else begin
        fail_cnt++;
        $error("valid_out high during stall");
    end

    we_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) mem_we |=> !mem_we
    ) else begin
        fail_cnt++;
        $error("mem_we high on two consecutive cycles");
    end

    // the popped entry leaves the queue one cycle before mem_we
    we_needs_store: assert property (
        @(posedge clk) disable iff (!arst_n) mem_we |-> $past(!wbaq_empty)
    ) else begin
        fail_cnt++;
        $error("mem_we without a queued store");
    end

endmodule

bind wb_top wb_properties u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .valid_out  (valid_out),
    .mem_we     (mem_we),
    .wbaq_empty (wbaq_empty)
);

/* wb_tb.sv */
module wb_tb
    import wb_pkg::*;
();

    localparam int N_RAND     = 12;
    localparam int STORE_CYC  = MEM_GAP + 2;
    localparam int T_RESET    = 16;
    localparam int T_REGS     = (N_RAND + 2) * (1 + NUM_REGS);
    localparam int T_ORDER    = 5 + 5 * STORE_CYC;
    localparam int T_FULL     = WBAQ_DEPTH + 2 * NUM_REGS + (WBAQ_DEPTH + 1) * STORE_CYC;
    localparam int T_BRANCH   = 6 + NUM_REGS + STORE_CYC;
    localparam int T_IE       = 8;
    localparam int MAX_CYCLES = 2 * (T_RESET + T_REGS + T_ORDER + T_FULL + T_BRANCH + T_IE) + 50;

    logic                  clk, arst_n, valid_in, mem_ready;
    logic [ADDR_W-1:0]     eip_in, br_fip_in;
    logic                  br_taken_in, br_correct_in, far_xfer, ie_in, interrupt_in;
    logic [3:0]            ie_type_in;
    logic [DATA_W-1:0]     inp1, inp2, inp3, inp4;
    logic [ADDR_W-1:0]     inp1_dest, inp2_dest, inp3_dest, inp4_dest;
    logic                  inp1_is_reg, inp2_is_reg, inp3_is_reg, inp4_is_reg;
    logic                  inp1_is_seg, inp2_is_seg, inp3_is_seg, inp4_is_seg;
    logic                  inp1_is_mem, inp2_is_mem, inp3_is_mem, inp4_is_mem;
    logic                  inp1_wb, inp2_wb, inp3_wb, inp4_wb;
    size_t                 inpsize;
    logic [REG_IDX_W-1:0]  gpr_rd_addr, seg_rd_addr;
    logic                  valid_out, stall, is_resteer, final_ie_val, mem_we;
    logic [ADDR_W-1:0]     new_eip, new_fip_e, new_fip_o, mem_waddr;
    logic [3:0]            final_ie_type;
    logic [DATA_W-1:0]     mem_wdata;
    size_t                 mem_wsize;
    gpr_t                  gpr_rd_data;
    seg_t                  seg_rd_data;

    // instruction being prepared
    logic [DATA_W-1:0]     s_data [NUM_SLOTS];
    logic [ADDR_W-1:0]     s_dest [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  s_reg, s_seg, s_mem, s_wb;
    size_t                 s_size;
    logic                  s_valid, s_far, s_taken, s_correct, s_ie, s_int;
    logic [3:0]            s_ie_type;
    logic [ADDR_W-1:0]     s_eip, s_fip;

    gpr_t                  gpr_model [NUM_REGS];
    seg_t                  seg_model [NUM_REGS];
    logic [ADDR_W-1:0]     exp_addr [$];
    logic [DATA_W-1:0]     exp_data [$];
    size_t                 exp_size [$];

    int                    err_value = 0;
    int                    err_other = 0;
    int                    cycle = 0;
    int                    last_we = -100;
    int                    we_count = 0;
    logic [31:0]           rng;

    wb_clkgen u_clk (.clk(clk));

    wb_top DUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            err_value++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_slots();
        s_valid   = 1'b1;
        s_far     = 1'b0;
        s_taken   = 1'b0;
        s_correct = 1'b1;
        s_ie      = 1'b0;
        s_int     = 1'b0;
        s_ie_type = 4'h0;
        s_eip     = 32'h0000_1000;
        s_fip     = 32'h0000_2000;
        s_size    = 2'd0;
        s_reg     = '0;
        s_seg     = '0;
        s_mem     = '0;
        s_wb      = '0;
        for (int n = 0; n < NUM_SLOTS; n++) begin
            s_data[n] = '0;
            s_dest[n] = '0;
        end
    endtask

    task automatic random_slots();
        for (int n = 0; n < NUM_SLOTS; n++) begin
            s_data[n] = {next_rand(), next_rand()};
            s_dest[n] = next_rand();
        end
        s_reg = NUM_SLOTS'(next_rand());
        s_seg = NUM_SLOTS'(next_rand());
        s_wb  = NUM_SLOTS'(next_rand());
    endtask

    // drive one instruction, check the stage outputs, update the model
    task automatic issue_instr(output logic accepted);
        logic              exp_stall;
        logic [ADDR_W-1:0] target;
        logic [ADDR_W-1:0] base;
        gpr_t              slot_val;
        int                st_slot;
        @(posedge clk);
        valid_in      <= s_valid;
        eip_in        <= s_eip;
        br_fip_in     <= s_fip;
        br_taken_in   <= s_taken;
        br_correct_in <= s_correct;
        far_xfer      <= s_far;
        ie_in         <= s_ie;
        ie_type_in    <= s_ie_type;
        interrupt_in  <= s_int;
        inpsize       <= s_size;
        {inp4, inp3, inp2, inp1} <= {s_data[3], s_data[2], s_data[1], s_data[0]};
        {inp4_dest, inp3_dest, inp2_dest, inp1_dest} <=
            {s_dest[3], s_dest[2], s_dest[1], s_dest[0]};
        {inp4_is_reg, inp3_is_reg, inp2_is_reg, inp1_is_reg} <= s_reg;
        {inp4_is_seg, inp3_is_seg, inp2_is_seg, inp1_is_seg} <= s_seg;
        {inp4_is_mem, inp3_is_mem, inp2_is_mem, inp1_is_mem} <= s_mem;
        {inp4_wb, inp3_wb, inp2_wb, inp1_wb} <= s_wb;
        @(negedge clk);
        exp_stall = s_valid && (s_mem != '0) && (exp_addr.size() == WBAQ_DEPTH);
        accepted  = s_valid && !exp_stall;
        compare("stall", stall, exp_stall);
        compare("valid_out", valid_out, accepted);
        target = s_far ? s_data[0][31:0] : s_fip;
        base   = {target[31:4], 4'h0};
        compare("new_eip", new_eip, s_taken ? target : s_eip);
        compare("new_fip_e", new_fip_e, target[4] ? base + 32'd16 : base);
        compare("new_fip_o", new_fip_o, target[4] ? base : base + 32'd16);
        compare("is_resteer", is_resteer, !s_correct);
        compare("final_ie_val", final_ie_val, s_ie | s_int);
        compare("final_ie_type", final_ie_type, {s_int, s_ie_type[2:0]});
        if (accepted) begin
            st_slot = -1;
            for (int n = 0; n < NUM_SLOTS; n++) begin
                slot_val = (n == 0 && s_far) ? {48'h0, s_data[0][47:32]} : s_data[n];
                if (s_reg[n] && s_wb[n]) begin
                    gpr_model[s_dest[n][2:0]] = slot_val;
                end
                if (s_seg[n] && s_wb[n]) begin
                    seg_model[s_dest[n][2:0]] = slot_val[15:0];
                end
                if (s_mem[n] && st_slot < 0) begin
                    st_slot = n;
                end
            end
            if (st_slot >= 0) begin
                exp_addr.push_back(s_dest[st_slot]);
                exp_data.push_back(s_data[st_slot]);
                exp_size.push_back(s_far ? 2'd3 : s_size);
            end
        end
    endtask

    task automatic read_back_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(posedge clk);
            valid_in    <= 1'b0;
            gpr_rd_addr <= REG_IDX_W'(r);
            seg_rd_addr <= REG_IDX_W'(r);
            @(negedge clk);
            compare($sformatf("gpr_rd_data[%0d]", r), gpr_rd_data, gpr_model[r]);
            compare($sformatf("seg_rd_data[%0d]", r), seg_rd_data, seg_model[r]);
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        valid_in <= 1'b0;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (MEM_GAP + 2) @(posedge clk);  // drain FSM back in IDLE
    endtask

    task automatic regs_writeback();
        logic ok;
        for (int i = 0; i < N_RAND; i++) begin
            clear_slots();
            random_slots();
            s_valid = (i % 4 != 3);
            if (i % 3 == 0) begin  // slots 3 and 4 hit the same register
                s_dest[3]  = s_dest[2];
                s_reg[3:2] = 2'b11;
                s_seg[3:2] = 2'b11;
                s_wb[3:2]  = 2'b11;
            end
            issue_instr(ok);
            read_back_regs();
        end
    endtask

    task automatic store_order();
        logic ok;
        int   base_count;
        @(posedge clk);
        mem_ready <= 1'b0;
        base_count = we_count;
        for (int k = 0; k < 5; k++) begin
            clear_slots();
            random_slots();
            s_mem[k % NUM_SLOTS] = 1'b1;
            s_mem[3]             = 1'b1;
            s_size               = size_t'(k);
            issue_instr(ok);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        repeat (STORE_CYC) @(posedge clk);
        assert (we_count == base_count) else begin
            err_other++;
            $display("memory write issued while mem_ready was low");
        end
        mem_ready <= 1'b1;
        wait_drained();
        assert (we_count == base_count + 5) else begin
            err_other++;
            $display("expected 5 memory writes, saw %0d", we_count - base_count);
        end
        read_back_regs();
    endtask

    task automatic full_stall();
        logic ok;
        @(posedge clk);
        mem_ready <= 1'b0;
        for (int k = 0; k < WBAQ_DEPTH; k++) begin
            clear_slots();
            random_slots();
            s_mem = 4'b0001;
            issue_instr(ok);
        end
        clear_slots();
        random_slots();
        s_mem     = 4'b0001;
        s_reg     = 4'b0010;
        s_seg     = 4'b0000;
        s_wb      = 4'b0010;
        s_dest[1] = 32'd5;
        issue_instr(ok);  // stalls on the full queue
        read_back_regs();
        @(posedge clk);
        mem_ready <= 1'b1;
        while (exp_addr.size() == WBAQ_DEPTH) begin
            @(posedge clk);
        end
        issue_instr(ok);  // same instruction again
        assert (valid_out && !stall) else begin
            err_other++;
            $display("held instruction was not accepted after the queue drained");
        end
        wait_drained();
        read_back_regs();
    endtask

    task automatic branch_redirect();
        logic        ok;
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            clear_slots();
            r         = next_rand();
            s_taken   = i[0];
            s_correct = i[1];
            s_fip     = {r[31:5], i[0] ^ i[1], r[3:0]};  // even and odd lines
            s_eip     = next_rand();
            issue_instr(ok);
        end
        clear_slots();
        s_far     = 1'b1;
        s_taken   = 1'b1;
        s_data[0] = {16'hdead, 16'h0023, 32'h0040_1238};  // junk above selector
        s_reg[0]  = 1'b1;
        s_seg[0]  = 1'b1;
        s_wb[0]   = 1'b1;
        s_dest[0] = 32'd2;
        s_mem[1]  = 1'b1;
        s_dest[1] = 32'h0000_8000;
        s_data[1] = {next_rand(), next_rand()};
        s_size    = 2'd1;
        issue_instr(ok);
        wait_drained();
        read_back_regs();
    endtask

    task automatic exception_merge();
        logic ok;
        for (int i = 0; i < 8; i++) begin
            clear_slots();
            s_ie      = i[0];
            s_int     = i[1];
            s_valid   = i[2];
            s_ie_type = 4'(next_rand());
            issue_instr(ok);
        end
    endtask

    // store checker on the memory write port
    always @(negedge clk) begin
        if (arst_n && mem_we) begin
            we_count++;
            assert (cycle - last_we >= MEM_GAP + 1) else begin
                err_other++;
                $display("memory writes only %0d cycles apart", cycle - last_we);
            end
            last_we = cycle;
            assert (exp_addr.size() != 0) else begin
                err_other++;
                $display("memory write seen with no store pending");
            end
            if (exp_addr.size() != 0) begin
                compare("mem_waddr", mem_waddr, exp_addr.pop_front());
                compare("mem_wdata", mem_wdata, exp_data.pop_front());
                compare("mem_wsize", mem_wsize, exp_size.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not finish", cycle);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int total;
        rng         = 32'h8ed1cc4c;
        arst_n      = 1'b0;
        valid_in    = 1'b0;
        mem_ready   = 1'b1;
        eip_in      = '0;
        br_fip_in   = '0;
        br_taken_in = 1'b0;
        br_correct_in = 1'b1;
        far_xfer    = 1'b0;
        ie_in       = 1'b0;
        ie_type_in  = '0;
        interrupt_in = 1'b0;
        inpsize     = '0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        {inp4, inp3, inp2, inp1} = '0;
        {inp4_dest, inp3_dest, inp2_dest, inp1_dest} = '0;
        {inp4_is_reg, inp3_is_reg, inp2_is_reg, inp1_is_reg} = '0;
        {inp4_is_seg, inp3_is_seg, inp2_is_seg, inp1_is_seg} = '0;
        {inp4_is_mem, inp3_is_mem, inp2_is_mem, inp1_is_mem} = '0;
        {inp4_wb, inp3_wb, inp2_wb, inp1_wb} = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            gpr_model[r] = '0;
            seg_model[r] = '0;
        end
        repeat (T_RESET) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare("mem_we", mem_we, 1'b0);
        read_back_regs();
        regs_writeback();
        store_order();
        full_stall();
        branch_redirect();
        exception_merge();
        wait_drained();
        total = err_value + err_other + DUT.u_props.fail_cnt;
        $display("errors: value %0d, other %0d, assertion %0d",
                 err_value, err_other, DUT.u_props.fail_cnt);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* wb_subsys.f */
wb_pkg.sv
wb_stage.sv
wb_regfile.sv
wbaq_fifo.sv
wbaq_drain_fsm.sv
wb_gap_timer.sv
wb_top.sv
wb_clkgen.sv
wb_properties.sv
wb_tb.sv

/* Makefile */
TOP       ?= wb_tb
FILELIST  ?= wb_subsys.f
LOG       ?= sim.log
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"
	@echo "variables: TOP FILELIST LOG VERILATOR FLAGS SIMARGS OBJDIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@if grep -q "Test failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL, run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
